// ==== amber_sys_pkg.sv ====
package amber_sys_pkg;

    // Bus widths
    localparam int WB_DWIDTH      = 32;
    localparam int WB_SWIDTH      = 4;
    localparam int WB_AWIDTH      = 32;
    localparam int BOOT_MEM_WORDS = 512;

    // Address map, page is adr[31:24]
    localparam logic [7:0] BOOT_MEM_PAGE = 8'h00;
    localparam logic [7:0] TIMER_PAGE    = 8'h13;
    localparam logic [7:0] IC_PAGE       = 8'h14;

    // Timer registers
    localparam logic [7:0] TM_LOAD  = 8'h00;
    localparam logic [7:0] TM_VALUE = 8'h04;
    localparam logic [7:0] TM_CTRL  = 8'h08;
    localparam logic [7:0] TM_CLEAR = 8'h0C;

    localparam int TM_CTRL_EN       = 7;
    localparam int TM_CTRL_PERIODIC = 6;

    // Interrupt controller registers
    localparam logic [7:0] IC_IRQ_STATUS  = 8'h00;
    localparam logic [7:0] IC_IRQ_RAW     = 8'h04;
    localparam logic [7:0] IC_IRQ_EN_SET  = 8'h08;
    localparam logic [7:0] IC_IRQ_EN_CLR  = 8'h0C;
    localparam logic [7:0] IC_FIRQ_STATUS = 8'h10;
    localparam logic [7:0] IC_FIRQ_EN_SET = 8'h18;
    localparam logic [7:0] IC_FIRQ_EN_CLR = 8'h1C;
    localparam logic [7:0] IC_SOFT_SET    = 8'h20;
    localparam logic [7:0] IC_SOFT_CLR    = 8'h24;

    localparam int IRQ_SOURCES   = 3;
    localparam int IRQ_BIT_SOFT  = 0;
    localparam int IRQ_BIT_EXT   = 1;
    localparam int IRQ_BIT_TIMER = 2;

    typedef enum logic [1:0] {SEL_BOOT, SEL_TIMER, SEL_IC, SEL_NONE} slave_sel_t;

endpackage

// ==== wb_if.sv ====
`timescale 1ns/1ns

// Wishbone classic bus, one master and one slave side
interface wb_if;

    logic [amber_sys_pkg::WB_AWIDTH-1:0] adr;
    logic [amber_sys_pkg::WB_SWIDTH-1:0] sel;
    logic                                we;
    logic [amber_sys_pkg::WB_DWIDTH-1:0] wdat;
    logic [amber_sys_pkg::WB_DWIDTH-1:0] rdat;
    logic                                cyc;
    logic                                stb;
    logic                                ack;
    logic                                err;

    modport master (
        output adr, sel, we, wdat, cyc, stb,
        input  rdat, ack, err
    );

    modport slave (
        input  adr, sel, we, wdat, cyc, stb,
        output rdat, ack, err
    );

endinterface

// ==== wb_arbiter.sv ====
`timescale 1ns/1ns

module wb_arbiter (
    input  logic  i_clk,
    input  logic  i_rst_n,
    wb_if.slave   m0,
    wb_if.slave   m1,
    wb_if.master  s_boot,
    wb_if.master  s_timer,
    wb_if.master  s_ic
);

    logic                                gnt_valid;
    logic                                gnt_m1;
    logic [amber_sys_pkg::WB_AWIDTH-1:0] g_adr;
    logic                                g_cyc;
    logic                                g_stb;
    logic                                g_act;
    amber_sys_pkg::slave_sel_t           slave_sel;
    logic                                err_r;
    logic                                resp_ack;
    logic                                resp_err;
    logic [amber_sys_pkg::WB_DWIDTH-1:0] resp_rdat;

    // --------------------------------------------------
    // Grant, held for the whole cyc of the owner
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gnt_valid <= 1'b0;
            gnt_m1    <= 1'b0;
        end else if (!(gnt_valid && g_cyc)) begin
            // Master 1 has priority
            gnt_valid <= m1.cyc || m0.cyc;
            gnt_m1    <= m1.cyc;
        end
    end

    assign g_adr = gnt_m1 ? m1.adr : m0.adr;
    assign g_cyc = gnt_m1 ? m1.cyc : m0.cyc;
    assign g_stb = gnt_m1 ? m1.stb : m0.stb;
    assign g_act = gnt_valid && g_cyc;

    // Page and offset decode
    always_comb begin
        slave_sel = amber_sys_pkg::SEL_NONE;
        if (g_adr[31:24] == amber_sys_pkg::BOOT_MEM_PAGE &&
            g_adr[23:$clog2(amber_sys_pkg::BOOT_MEM_WORDS) + 2] == '0)
            slave_sel = amber_sys_pkg::SEL_BOOT;
        else if (g_adr[31:24] == amber_sys_pkg::TIMER_PAGE && g_adr[23:4] == '0)
            slave_sel = amber_sys_pkg::SEL_TIMER;
        else if (g_adr[31:24] == amber_sys_pkg::IC_PAGE && g_adr[23:6] == '0)
            slave_sel = amber_sys_pkg::SEL_IC;
    end

    // --------------------------------------------------
    // Request routing
    // --------------------------------------------------
    assign s_boot.adr   = g_adr;
    assign s_boot.sel   = gnt_m1 ? m1.sel  : m0.sel;
    assign s_boot.we    = gnt_m1 ? m1.we   : m0.we;
    assign s_boot.wdat  = gnt_m1 ? m1.wdat : m0.wdat;
    assign s_boot.cyc   = g_act && slave_sel == amber_sys_pkg::SEL_BOOT;
    assign s_boot.stb   = s_boot.cyc && g_stb;

    assign s_timer.adr  = g_adr;
    assign s_timer.sel  = s_boot.sel;
    assign s_timer.we   = s_boot.we;
    assign s_timer.wdat = s_boot.wdat;
    assign s_timer.cyc  = g_act && slave_sel == amber_sys_pkg::SEL_TIMER;
    assign s_timer.stb  = s_timer.cyc && g_stb;

    assign s_ic.adr     = g_adr;
    assign s_ic.sel     = s_boot.sel;
    assign s_ic.we      = s_boot.we;
    assign s_ic.wdat    = s_boot.wdat;
    assign s_ic.cyc     = g_act && slave_sel == amber_sys_pkg::SEL_IC;
    assign s_ic.stb     = s_ic.cyc && g_stb;

    // Error pulse for holes in the map
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            err_r <= 1'b0;
        else
            err_r <= g_act && g_stb && slave_sel == amber_sys_pkg::SEL_NONE && !err_r;
    end

    // --------------------------------------------------
    // Response routing
    // --------------------------------------------------
    always_comb begin
        resp_ack  = 1'b0;
        resp_err  = err_r;
        resp_rdat = '0;
        case (slave_sel)
            amber_sys_pkg::SEL_BOOT:  begin
                resp_ack  = s_boot.ack;
                resp_err  = s_boot.err;
                resp_rdat = s_boot.rdat;
            end
            amber_sys_pkg::SEL_TIMER: begin
                resp_ack  = s_timer.ack;
                resp_err  = s_timer.err;
                resp_rdat = s_timer.rdat;
            end
            amber_sys_pkg::SEL_IC:    begin
                resp_ack  = s_ic.ack;
                resp_err  = s_ic.err;
                resp_rdat = s_ic.rdat;
            end
            default: ;
        endcase
    end

    assign m0.rdat = resp_rdat;
    assign m1.rdat = resp_rdat;
    assign m0.ack  = gnt_valid && !gnt_m1 && resp_ack;
    assign m0.err  = gnt_valid && !gnt_m1 && resp_err;
    assign m1.ack  = gnt_valid && gnt_m1 && resp_ack;
    assign m1.err  = gnt_valid && gnt_m1 && resp_err;

    a_resp_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(m0.ack && m0.err) && !(m1.ack && m1.err));

    a_grant_lock: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        g_act |=> gnt_valid && $stable(gnt_m1));

endmodule

// ==== boot_mem.sv ====
`timescale 1ns/1ns

module boot_mem (
    input  logic  i_clk,
    input  logic  i_rst_n,
    wb_if.slave   bus
);

    logic [amber_sys_pkg::WB_DWIDTH-1:0] mem [amber_sys_pkg::BOOT_MEM_WORDS];
    logic [$clog2(amber_sys_pkg::BOOT_MEM_WORDS)-1:0] word_adr;
    logic                                req;

    // Byte address to word index
    assign word_adr = bus.adr[$clog2(amber_sys_pkg::BOOT_MEM_WORDS) + 1:2];
    assign req      = bus.cyc && bus.stb && !bus.ack;
    assign bus.err  = 1'b0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            bus.ack <= 1'b0;
        else
            bus.ack <= req;
    end

    // SRAM array with per-lane writes
    always_ff @(posedge i_clk) begin
        if (req && bus.we) begin
            for (int i = 0; i < amber_sys_pkg::WB_SWIDTH; i++) begin
                if (bus.sel[i])
                    mem[word_adr][8*i +: 8] <= bus.wdat[8*i +: 8];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req)
            bus.rdat <= mem[word_adr];
    end

    a_ack_after_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        bus.ack |-> $past(bus.stb));

endmodule

// ==== timer_module.sv ====
`timescale 1ns/1ns

module timer_module (
    input  logic  i_clk,
    input  logic  i_rst_n,
    wb_if.slave   bus,
    output logic  o_timer_int
);

    logic [amber_sys_pkg::WB_DWIDTH-1:0] load_r;
    logic [amber_sys_pkg::WB_DWIDTH-1:0] value_r;
    logic [7:0]                          ctrl_r;
    logic                                req;
    logic                                wr;
    logic                                enabled;

    assign req     = bus.cyc && bus.stb && !bus.ack;
    assign wr      = req && bus.we;
    assign enabled = ctrl_r[amber_sys_pkg::TM_CTRL_EN];
    assign bus.err = 1'b0;

    // --------------------------------------------------
    // Registers and down counter
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bus.ack     <= 1'b0;
            load_r      <= '0;
            value_r     <= '0;
            ctrl_r      <= '0;
            o_timer_int <= 1'b0;
        end else begin
            bus.ack <= req;

            if (wr && bus.adr[7:0] == amber_sys_pkg::TM_CTRL)
                ctrl_r <= bus.wdat[7:0];

            // A load restarts the count
            if (wr && bus.adr[7:0] == amber_sys_pkg::TM_LOAD) begin
                load_r  <= bus.wdat;
                value_r <= bus.wdat;
            end else if (enabled) begin
                if (value_r != '0)
                    value_r <= value_r - 1'b1;
                else if (ctrl_r[amber_sys_pkg::TM_CTRL_PERIODIC])
                    value_r <= load_r;
            end

            // Set on the step into zero
            if (wr && bus.adr[7:0] == amber_sys_pkg::TM_CLEAR)
                o_timer_int <= 1'b0;
            else if (enabled && value_r == 1)
                o_timer_int <= 1'b1;
        end
    end

    // Register read-back
    always_ff @(posedge i_clk) begin
        if (req) begin
            case (bus.adr[7:0])
                amber_sys_pkg::TM_LOAD:  bus.rdat <= load_r;
                amber_sys_pkg::TM_VALUE: bus.rdat <= value_r;
                amber_sys_pkg::TM_CTRL:  bus.rdat <= {24'd0, ctrl_r};
                default:                 bus.rdat <= '0;
            endcase
        end
    end

    a_count_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        value_r <= load_r);

endmodule

// ==== interrupt_controller.sv ====
`timescale 1ns/1ns

module interrupt_controller (
    input  logic  i_clk,
    input  logic  i_rst_n,
    wb_if.slave   bus,
    input  logic  i_ext_int,
    input  logic  i_timer_int,
    output logic  o_irq,
    output logic  o_firq
);

    logic [amber_sys_pkg::IRQ_SOURCES-1:0] raw;
    logic [amber_sys_pkg::IRQ_SOURCES-1:0] irq_en;
    logic [amber_sys_pkg::IRQ_SOURCES-1:0] firq_en;
    logic [amber_sys_pkg::IRQ_SOURCES-1:0] irq_st;
    logic [amber_sys_pkg::IRQ_SOURCES-1:0] firq_st;
    logic [amber_sys_pkg::IRQ_SOURCES-1:0] wbits;
    logic                                  soft_r;
    logic                                  req;
    logic                                  wr;

    assign req     = bus.cyc && bus.stb && !bus.ack;
    assign wr      = req && bus.we;
    assign wbits   = bus.wdat[amber_sys_pkg::IRQ_SOURCES-1:0];
    assign bus.err = 1'b0;

    always_comb begin
        raw = '0;
        raw[amber_sys_pkg::IRQ_BIT_SOFT]  = soft_r;
        raw[amber_sys_pkg::IRQ_BIT_EXT]   = i_ext_int;
        raw[amber_sys_pkg::IRQ_BIT_TIMER] = i_timer_int;
    end

    assign irq_st  = raw & irq_en;
    assign firq_st = raw & firq_en;

    // --------------------------------------------------
    // Enable masks, set and clear by writing ones
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bus.ack <= 1'b0;
            irq_en  <= '0;
            firq_en <= '0;
            soft_r  <= 1'b0;
            o_irq   <= 1'b0;
            o_firq  <= 1'b0;
        end else begin
            bus.ack <= req;
            if (wr) begin
                case (bus.adr[7:0])
                    amber_sys_pkg::IC_IRQ_EN_SET:  irq_en  <= irq_en | wbits;
                    amber_sys_pkg::IC_IRQ_EN_CLR:  irq_en  <= irq_en & ~wbits;
                    amber_sys_pkg::IC_FIRQ_EN_SET: firq_en <= firq_en | wbits;
                    amber_sys_pkg::IC_FIRQ_EN_CLR: firq_en <= firq_en & ~wbits;
                    amber_sys_pkg::IC_SOFT_SET:    soft_r  <= soft_r | bus.wdat[0];
                    amber_sys_pkg::IC_SOFT_CLR:    soft_r  <= soft_r & ~bus.wdat[0];
                    default: ;
                endcase
            end
            o_irq  <= |irq_st;
            o_firq <= |firq_st;
        end
    end

    // Status read-back, enables visible at their set offsets
    always_ff @(posedge i_clk) begin
        if (req) begin
            bus.rdat <= '0;
            case (bus.adr[7:0])
                amber_sys_pkg::IC_IRQ_STATUS:  bus.rdat[2:0] <= irq_st;
                amber_sys_pkg::IC_IRQ_RAW:     bus.rdat[2:0] <= raw;
                amber_sys_pkg::IC_IRQ_EN_SET:  bus.rdat[2:0] <= irq_en;
                amber_sys_pkg::IC_FIRQ_STATUS: bus.rdat[2:0] <= firq_st;
                amber_sys_pkg::IC_FIRQ_EN_SET: bus.rdat[2:0] <= firq_en;
                amber_sys_pkg::IC_SOFT_SET:    bus.rdat[0]   <= soft_r;
                default: ;
            endcase
        end
    end

endmodule

// ==== msystem_top.sv ====
`timescale 1ns/1ns

module msystem_top (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    // Master 0, DMA side
    input  logic [amber_sys_pkg::WB_AWIDTH-1:0] i_m0_adr,
    input  logic [amber_sys_pkg::WB_SWIDTH-1:0] i_m0_sel,
    input  logic                                i_m0_we,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0] i_m0_wdat,
    input  logic                                i_m0_cyc,
    input  logic                                i_m0_stb,
    output logic [amber_sys_pkg::WB_DWIDTH-1:0] o_m0_rdat,
    output logic                                o_m0_ack,
    output logic                                o_m0_err,
    // Master 1, core side
    input  logic [amber_sys_pkg::WB_AWIDTH-1:0] i_m1_adr,
    input  logic [amber_sys_pkg::WB_SWIDTH-1:0] i_m1_sel,
    input  logic                                i_m1_we,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0] i_m1_wdat,
    input  logic                                i_m1_cyc,
    input  logic                                i_m1_stb,
    output logic [amber_sys_pkg::WB_DWIDTH-1:0] o_m1_rdat,
    output logic                                o_m1_ack,
    output logic                                o_m1_err,
    input  logic                                i_ext_int,
    output logic                                o_irq,
    output logic                                o_firq
);

    wb_if m0_bus ();
    wb_if m1_bus ();
    wb_if boot_bus ();
    wb_if timer_bus ();
    wb_if ic_bus ();

    logic timer_int;

    // --------------------------------------------------
    // Master ports onto the bus
    // --------------------------------------------------
    assign m0_bus.adr  = i_m0_adr;
    assign m0_bus.sel  = i_m0_sel;
    assign m0_bus.we   = i_m0_we;
    assign m0_bus.wdat = i_m0_wdat;
    assign m0_bus.cyc  = i_m0_cyc;
    assign m0_bus.stb  = i_m0_stb;
    assign o_m0_rdat   = m0_bus.rdat;
    assign o_m0_ack    = m0_bus.ack;
    assign o_m0_err    = m0_bus.err;

    assign m1_bus.adr  = i_m1_adr;
    assign m1_bus.sel  = i_m1_sel;
    assign m1_bus.we   = i_m1_we;
    assign m1_bus.wdat = i_m1_wdat;
    assign m1_bus.cyc  = i_m1_cyc;
    assign m1_bus.stb  = i_m1_stb;
    assign o_m1_rdat   = m1_bus.rdat;
    assign o_m1_ack    = m1_bus.ack;
    assign o_m1_err    = m1_bus.err;

    wb_arbiter u_wb_arbiter (
        .i_clk   ( i_clk     ),
        .i_rst_n ( i_rst_n   ),
        .m0      ( m0_bus    ),
        .m1      ( m1_bus    ),
        .s_boot  ( boot_bus  ),
        .s_timer ( timer_bus ),
        .s_ic    ( ic_bus    )
    );

    boot_mem u_boot_mem (
        .i_clk   ( i_clk    ),
        .i_rst_n ( i_rst_n  ),
        .bus     ( boot_bus )
    );

    timer_module u_timer_module (
        .i_clk       ( i_clk     ),
        .i_rst_n     ( i_rst_n   ),
        .bus         ( timer_bus ),
        .o_timer_int ( timer_int )
    );

    interrupt_controller u_interrupt_controller (
        .i_clk       ( i_clk     ),
        .i_rst_n     ( i_rst_n   ),
        .bus         ( ic_bus    ),
        .i_ext_int   ( i_ext_int ),
        .i_timer_int ( timer_int ),
        .o_irq       ( o_irq     ),
        .o_firq      ( o_firq    )
    );

endmodule

// ==== tb_msystem.sv ====
`timescale 1ns/1ns

module tb_msystem;

    localparam int STIM_LINES  = 64;
    localparam int BUS_TIMEOUT = 20;

    logic        i_clk;
    logic        i_rst_n;
    logic [31:0] i_m0_adr, i_m1_adr, i_m0_wdat, i_m1_wdat;
    logic [3:0]  i_m0_sel, i_m1_sel;
    logic        i_m0_we, i_m1_we, i_m0_cyc, i_m1_cyc, i_m0_stb, i_m1_stb;
    logic [31:0] o_m0_rdat, o_m1_rdat;
    logic        o_m0_ack, o_m1_ack, o_m0_err, o_m1_err;
    logic        i_ext_int, o_irq, o_firq;

    logic [31:0] stim_mem [STIM_LINES*5];
    logic [31:0] op, adr, dat, expv, rdat_s;
    logic        ack_s, err_s, m0_cyc_q, m1_cyc_q, timed_out, stop;
    int          m, line_no, cycle_cnt, last_ack_cycle;
    int          err_cnt, test_err, check_cnt, tests_run;

    msystem_top UUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        m0_cyc_q  <= i_m0_cyc;
        m1_cyc_q  <= i_m1_cyc;
    end

    // A response on a port whose master had no cycle open
    always @(negedge i_clk) begin
        if ((o_m0_ack || o_m0_err) && !m0_cyc_q || (o_m1_ack || o_m1_err) && !m1_cyc_q) begin
            $display("Error at %0t ns: a master got a response to a transfer it did not start",
                     $time);
            err_cnt++;
            test_err++;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s (got %h, expected %h)", $time, msg, got, exp);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic drive_master(input int mst, input logic act, input logic we,
                                input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        if (mst == 0) begin
            i_m0_cyc  = act;
            i_m0_stb  = act;
            i_m0_we   = we;
            i_m0_adr  = a;
            i_m0_wdat = d;
            i_m0_sel  = s;
        end else begin
            i_m1_cyc  = act;
            i_m1_stb  = act;
            i_m1_we   = we;
            i_m1_adr  = a;
            i_m1_wdat = d;
            i_m1_sel  = s;
        end
    endtask

    // --------------------------------------------------
    // One Wishbone classic transfer on one master
    // --------------------------------------------------
    task automatic bus_xfer(input int mst, input logic we, input logic [31:0] a,
                            input logic [31:0] d, input logic [3:0] s,
                            output logic [31:0] rd, output logic got_ack, output logic got_err);
        int wait_cnt;
        got_ack  = 1'b0;
        got_err  = 1'b0;
        rd       = '0;
        wait_cnt = 0;
        @(negedge i_clk);
        drive_master(mst, 1'b1, we, a, d, s);
        while (!got_ack && !got_err && wait_cnt < BUS_TIMEOUT) begin
            @(negedge i_clk);
            wait_cnt++;
            got_ack = (mst == 0) ? o_m0_ack : o_m1_ack;
            got_err = (mst == 0) ? o_m0_err : o_m1_err;
            rd      = (mst == 0) ? o_m0_rdat : o_m1_rdat;
        end
        drive_master(mst, 1'b0, 1'b0, 32'd0, $urandom, 4'd0);
        if (got_ack || got_err) begin
            last_ack_cycle = cycle_cnt;
        end else begin
            $display("Timeout: master %0d got neither ack nor err for address %h", mst, a);
            timed_out = 1'b1;
        end
    endtask

    // Both masters read from a random start gap
    task automatic paired_read(input int base);
        logic [31:0] rd0, rd1;
        logic        a0, e0, a1, e1;
        int          gap0, gap1;
        gap0 = $urandom % 2;
        gap1 = $urandom % 2;
        fork
            begin
                repeat (gap0) @(negedge i_clk);
                bus_xfer(stim_mem[base*5+1], 1'b0, stim_mem[base*5+2], 32'd0, 4'hf, rd0, a0, e0);
            end
            begin
                repeat (gap1) @(negedge i_clk);
                bus_xfer(stim_mem[base*5+6], 1'b0, stim_mem[base*5+7], 32'd0, 4'hf, rd1, a1, e1);
            end
        join
        check({30'd0, e0, a0}, 32'd1, "first paired read response");
        check(rd0, stim_mem[base*5+4], "first paired read data");
        check({30'd0, e1, a1}, 32'd1, "second paired read response");
        check(rd1, stim_mem[base*5+9], "second paired read data");
    endtask

    task automatic wait_levels(input int min_cyc, input int max_cyc, input logic [1:0] exp);
        int   elapsed;
        logic hit;
        hit     = 1'b0;
        elapsed = cycle_cnt - last_ack_cycle;
        while (!hit && elapsed < max_cyc) begin
            @(negedge i_clk);
            elapsed = cycle_cnt - last_ack_cycle;
            hit     = ({o_firq, o_irq} == exp);
        end
        if (!hit) begin
            $display("Timeout: irq and firq did not reach %b within %0d cycles", exp, max_cyc);
            timed_out = 1'b1;
        end else if (elapsed < min_cyc) begin
            $display("Error at %0t ns: interrupt levels changed after %0d cycles, minimum is %0d",
                     $time, elapsed, min_cyc);
            err_cnt++;
            test_err++;
        end
    endtask

    function automatic string test_name(input int n);
        case (n)
            1:       return "boot memory read-back";
            2:       return "unmapped address";
            3:       return "two masters";
            4:       return "one-shot timer";
            5:       return "interrupt masking";
            default: return "unnamed";
        endcase
    endfunction

    // --------------------------------------------------
    // Sequencer over the stimulus file
    // --------------------------------------------------
    initial begin
        i_rst_n = 1'b0;
        i_ext_int = 1'b0;
        drive_master(0, 1'b0, 1'b0, 32'd0, 32'd0, 4'd0);
        drive_master(1, 1'b0, 1'b0, 32'd0, 32'd0, 4'd0);
        {err_cnt, test_err, check_cnt, tests_run, cycle_cnt, last_ack_cycle} = '0;
        {timed_out, stop, m0_cyc_q, m1_cyc_q} = '0;
        void'($urandom(32'hdc89));
        $readmemh("msystem_stim.txt", stim_mem);
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check({26'd0, o_m0_ack, o_m1_ack, o_m0_err, o_m1_err, o_irq, o_firq}, 32'd0,
              "outputs after reset");
        line_no = 0;
        while (!stop && !timed_out && line_no < STIM_LINES) begin
            op   = stim_mem[line_no*5];
            m    = stim_mem[line_no*5+1];
            adr  = stim_mem[line_no*5+2];
            dat  = stim_mem[line_no*5+3];
            expv = stim_mem[line_no*5+4];
            case (op)
                32'd0: stop = 1'b1;
                32'd1: begin
                    bus_xfer(m, 1'b1, adr, dat, expv[3:0], rdat_s, ack_s, err_s);
                    check({30'd0, err_s, ack_s}, 32'd1, $sformatf("write ack at %h", adr));
                end
                32'd2: begin
                    bus_xfer(m, 1'b0, adr, 32'd0, 4'hf, rdat_s, ack_s, err_s);
                    check({30'd0, err_s, ack_s}, 32'd1, $sformatf("read ack at %h", adr));
                    check(rdat_s, expv, $sformatf("read data at %h", adr));
                end
                32'd3: begin
                    bus_xfer(m, 1'b0, adr, 32'd0, 4'hf, rdat_s, ack_s, err_s);
                    check({30'd0, err_s, ack_s}, 32'd2, $sformatf("err for unmapped %h", adr));
                end
                32'd4: begin
                    @(negedge i_clk);
                    i_ext_int = dat[0];
                end
                32'd5: wait_levels(adr, dat, expv[1:0]);
                32'd6: begin
                    paired_read(line_no);
                    line_no++;
                end
                32'd7: begin
                    $display("Test %0d (%s) finished with %0d errors", dat, test_name(dat),
                             test_err);
                    test_err = 0;
                    tests_run++;
                end
                default: begin
                    $display("Error: unknown operation %h on stimulus line %0d", op, line_no);
                    err_cnt++;
                    stop = 1'b1;
                end
            endcase
            line_no++;
        end
        if (timed_out) begin
            err_cnt++;
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, check_cnt, err_cnt);
        if (err_cnt == 0 && tests_run == 5) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== src.f ====
amber_sys_pkg.sv
wb_if.sv
wb_arbiter.sv
boot_mem.sv
timer_module.sv
interrupt_controller.sv
msystem_top.sv
tb_msystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_msystem --Mdir obj_dir -o tb_msystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_msystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    exit 1
fi
exit 0

// ==== msystem_stim.txt ====
// op master address data expected (write: expected = sel, wait: address = min, data = max)
// op 1 write, 2 read, 3 unmapped, 4 ext level, 5 wait irq/firq, 6 paired read, 7 test end, 0 stop
1 1 00000010 11223344 f
1 1 00000010 55667788 3
1 1 000007fc deadbeef f
1 1 000007fc 01020304 9
2 0 00000010 0 11227788
2 0 000007fc 0 01adbe04
7 0 0 1 0
3 1 00000800 0 0
3 0 13000010 0 0
2 0 00000010 0 11227788
7 0 0 2 0
6 0 00000010 0 11227788
6 1 000007fc 0 01adbe04
7 0 0 3 0
1 1 14000008 4 f
1 1 13000000 14 f
1 1 13000008 80 f
5 0 14 1e 1
2 0 13000004 0 0
1 1 1300000c 0 f
5 0 0 4 0
1 1 1400000c 4 f
7 0 0 4 0
1 1 14000020 1 f
4 0 0 1 0
2 0 14000004 0 3
1 1 14000008 1 f
1 0 14000018 2 f
2 1 14000000 0 1
2 1 14000010 0 2
5 0 0 4 3
1 1 1400000c 1 f
5 0 0 4 2
7 0 0 5 0
0 0 0 0 0
